/* filelist.f */
+incdir+rtl
+incdir+verif
rtl/mem_types_pkg.sv
rtl/mem_pipe_pkg.sv
rtl/mem_req_decode.sv
rtl/mem_bank_array.sv
rtl/mem_write_merge.sv
rtl/main_memory_top.sv
verif/tb_main_memory.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the main memory testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
    -f filelist.f \
    --top-module tb_main_memory \
    --Mdir obj_dir \
    -o sim_main

./obj_dir/sim_main | tee "$LOG"

if grep -q "All checks passed" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

/* verif/tb_mem_model.svh */
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// reference copy of the memory, one entry per word
// flat word number is addr[11:2], bank times 32 plus index
logic [31:0] model_mem [0:1023];

// new word after a write of the given size
function automatic logic [31:0] merge_write(
    input logic [31:0] old_word,
    input logic [1:0]  size,
    input logic [31:0] a,
    input logic [31:0] data
);
    logic [31:0] result;
    int          lane;
    result = old_word;
    lane   = int'(a[1:0]);
    if (size == `MEM_SIZE_BYTE) begin
        // low byte of data lands in the addressed lane
        result[8*lane +: 8] = data[7:0];
    end else if (size == `MEM_SIZE_HALF) begin
        // addr bit 0 plays no part
        if (a[1]) begin
            result[31:16] = data[15:0];
        end else begin
            result[15:0] = data[15:0];
        end
    end else begin
        // word, and code 3 the same way
        result = data;
    end
    return result;
endfunction

// 32-bit xorshift step, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

/* verif/tb_main_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module tb_main_memory;

    logic        clk;
    logic        rst_n;
    logic        en;
    logic        rd_wr;
    logic [1:0]  wr_size;
    logic [31:0] addr;
    logic [31:0] wr_data;
    logic        ready;
    logic        rd_valid;
    logic [31:0] rd_data;

    `include "tb_mem_model.svh"

    // expected read words with the oldest first
    logic [31:0] exp_q [$];
    // accepted reads with bit 2 due at this negedge
    logic [2:0]  rd_pipe = 3'b000;
    // rst_n as it stood one negedge ago
    logic        rst_prev = 1'b0;
    logic [31:0] rng_state = 32'h19895f4e;
    int          err_cnt = 0;
    int          timeout_cnt = 0;
    int          read_cnt = 0;

    main_memory_top i_main_memory_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .rd_wr    (rd_wr),
        .wr_size  (wr_size),
        .addr     (addr),
        .wr_data  (wr_data),
        .ready    (ready),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // one word in bank b with its index spread away from b
    function automatic logic [31:0] bank_addr(input int b);
        return (32'(b % 32) << 7) | (32'((b * 3 + 1) % 32) << 2);
    endfunction

    // 64 random-test words with two per bank at distinct indices
    function automatic logic [31:0] pool_addr(input int k);
        return (32'(k % 32) << 7) | (32'((k * 5 + (k / 32) * 17) % 32) << 2);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %08h, expected %08h at %0t", name, got, exp, $time);
            err_cnt++;
        end
    endtask

    // request goes out now and is accepted at the next edge
    task automatic send_request(input logic wr, input logic [1:0] size,
                                input logic [31:0] a, input logic [31:0] d);
        @(posedge clk);
        en      <= 1'b1;
        rd_wr   <= wr;
        wr_size <= size;
        addr    <= a;
        wr_data <= d;
        // model follows acceptance order
        if (wr) begin
            model_mem[a[11:2]] = merge_write(model_mem[a[11:2]], size, a, d);
        end else begin
            exp_q.push_back(model_mem[a[11:2]]);
        end
    endtask

    // en low with junk on the rest
    task automatic idle_cycle();
        @(posedge clk);
        en      <= 1'b0;
        rd_wr   <= rng_state[0];
        addr    <= rand_word();
        wr_data <= rand_word();
    endtask

    task automatic wait_for_ready();
        int n;
        n = 0;
        while (ready !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (ready !== 1'b1) begin
            $display("timeout: ready never went high after reset");
            timeout_cnt++;
        end
    endtask

    // every bank written once and then read back
    task automatic sweep_banks();
        for (int b = 0; b < 32; b++) begin
            send_request(1'b1, `MEM_SIZE_WORD, bank_addr(b), rand_word());
        end
        idle_cycle();
        for (int b = 0; b < 32; b++) begin
            send_request(1'b0, `MEM_SIZE_WORD, bank_addr(b), 32'h0);
        end
    endtask

    // byte and half at each offset with a gap before the read
    task automatic write_lanes();
        for (int off = 0; off < 4; off++) begin
            send_request(1'b1, `MEM_SIZE_BYTE, bank_addr(5) + 32'(off), rand_word());
            idle_cycle();
            idle_cycle();
            send_request(1'b0, `MEM_SIZE_WORD, bank_addr(5) + 32'(off), 32'h0);
        end
        for (int off = 0; off < 4; off++) begin
            send_request(1'b1, `MEM_SIZE_HALF, bank_addr(6) + 32'(off), rand_word());
            idle_cycle();
            idle_cycle();
            send_request(1'b0, `MEM_SIZE_WORD, bank_addr(6), 32'h0);
        end
    endtask

    // read right behind a write of the same word
    task automatic check_forwarding();
        for (int k = 0; k < 8; k++) begin
            send_request(1'b1, `MEM_SIZE_WORD, bank_addr(k * 4 + 2), rand_word());
            send_request(1'b0, `MEM_SIZE_WORD, bank_addr(k * 4 + 2), 32'h0);
            send_request(1'b1, 2'(k % 2), bank_addr(k * 4 + 2) + 32'(k % 4), rand_word());
            send_request(1'b0, `MEM_SIZE_WORD, bank_addr(k * 4 + 2), 32'h0);
        end
    endtask

    // partial writes piling up on one word through forwarding
    task automatic chain_partial_writes();
        send_request(1'b1, `MEM_SIZE_BYTE, bank_addr(9) + 32'd1, rand_word());
        send_request(1'b1, `MEM_SIZE_BYTE, bank_addr(9) + 32'd3, rand_word());
        send_request(1'b1, `MEM_SIZE_HALF, bank_addr(9) + 32'd0, rand_word());
        send_request(1'b0, `MEM_SIZE_WORD, bank_addr(9), 32'h0);
        // same again with one gap between writes
        send_request(1'b1, `MEM_SIZE_BYTE, bank_addr(9) + 32'd2, rand_word());
        idle_cycle();
        send_request(1'b1, `MEM_SIZE_HALF, bank_addr(9) + 32'd1, rand_word());
        send_request(1'b0, `MEM_SIZE_WORD, bank_addr(9), 32'h0);
    endtask

    task automatic random_mix(input int cycles);
        logic [31:0] r;
        logic [31:0] a;
        // full words first so no read returns unknown data
        for (int k = 0; k < 64; k++) begin
            send_request(1'b1, `MEM_SIZE_WORD, pool_addr(k), rand_word());
        end
        for (int i = 0; i < cycles; i++) begin
            r = rand_word();
            if (r[1:0] != 2'b00) begin
                a = pool_addr(int'(r[7:2])) | {30'b0, r[9:8]};
                send_request(r[10], r[12:11], a, rand_word());
            end else begin
                idle_cycle();
            end
        end
    endtask

    task automatic drain_responses();
        int n;
        idle_cycle();
        n = 0;
        while ((exp_q.size() != 0 || rd_pipe != 3'b000) && n < 16) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0 || rd_pipe != 3'b000) begin
            $display("timeout: %0d read responses never arrived", exp_q.size());
            timeout_cnt++;
        end
        // watch a few quiet cycles for a stray rd_valid
        repeat (4) idle_cycle();
    endtask

    // response side sampled away from the rising edge
    always @(negedge clk) begin : response_check
        logic        exp_ready;
        logic        exp_valid;
        logic [31:0] exp_word;
        // ready rises one edge after rst_n
        exp_ready = rst_prev;
        exp_valid = rd_pipe[2];
        check_value("ready", {31'b0, ready}, {31'b0, exp_ready});
        check_value("rd_valid", {31'b0, rd_valid}, {31'b0, exp_valid});
        if (exp_valid) begin
            if (exp_q.size() == 0) begin
                $display("a read response was due but no expected word was queued");
                err_cnt++;
            end else begin
                exp_word = exp_q.pop_front();
                check_value("rd_data", rd_data, exp_word);
                read_cnt++;
            end
        end
        // request on the pins now is taken at the next edge
        rd_pipe  = {rd_pipe[1:0], en & exp_ready & ~rd_wr};
        rst_prev = rst_n;
    end

    initial begin
        rst_n   = 1'b0;
        en      = 1'b0;
        rd_wr   = 1'b0;
        wr_size = 2'b00;
        addr    = 32'h0;
        wr_data = 32'h0;
        // reset held for 8 cycles
        repeat (8) @(negedge clk);
        @(posedge clk);
        rst_n <= 1'b1;
        wait_for_ready();
        if (timeout_cnt == 0) begin
            sweep_banks();
            write_lanes();
            check_forwarding();
            chain_partial_writes();
            random_mix(2000);
            drain_responses();
        end
        $display("reads checked %0d, errors %0d, timeouts %0d", read_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/main_memory_top.sv */
`timescale 1ns/1ps
`default_nettype none

module main_memory_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // request side
    input  logic                     en,
    input  logic                     rd_wr,
    input  mem_types_pkg::wr_size_t  wr_size,
    input  mem_types_pkg::mem_addr_t addr,
    input  mem_types_pkg::mem_word_t wr_data,
    // status and response
    output logic                     ready,
    output logic                     rd_valid,
    output mem_types_pkg::mem_word_t rd_data
);

    // loose ports gathered into one request
    mem_pipe_pkg::mem_req_t     req;
    // stage 1 to stage 2
    mem_pipe_pkg::decoded_req_t dec;
    // stage 2 to stage 3
    mem_pipe_pkg::read_stage_t  rd_item;
    // stage 3 write back into the banks
    mem_pipe_pkg::bank_wr_t     wr;

    assign req = '{
        rd_wr:   rd_wr,
        wr_size: wr_size,
        addr:    addr,
        wr_data: wr_data
    };

    // capture and align
    mem_req_decode i_mem_req_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .req   (req),
        .ready (ready),
        .dec   (dec)
    );

    // bank read with forwarding
    mem_bank_array i_mem_bank_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec),
        .wr      (wr),
        .rd_item (rd_item)
    );

    // merge, write back, read response
    mem_write_merge i_mem_write_merge (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_item  (rd_item),
        .wr       (wr),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

/* rtl/mem_write_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_write_merge (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mem_pipe_pkg::read_stage_t rd_item,
    output mem_pipe_pkg::bank_wr_t    wr,
    output logic                      rd_valid,
    output mem_types_pkg::mem_word_t  rd_data
);

    // old word with the new lanes laid over it
    mem_types_pkg::mem_word_t merged;
    logic                     is_write;
    logic                     is_read;

    assign is_write = rd_item.req.valid & rd_item.req.rd_wr;
    assign is_read  = rd_item.req.valid & ~rd_item.req.rd_wr;

    // lane by lane merge
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (rd_item.req.byte_en[i]) begin
                merged[8*i +: 8] = rd_item.req.wr_data[8*i +: 8];
            end else begin
                // untouched lane keeps what the bank held
                merged[8*i +: 8] = rd_item.old_word[8*i +: 8];
            end
        end
    end

    // write port back into stage 2
    // commits at the same edge stage 3 registers
    always_comb begin
        wr.wr_en = is_write;
        wr.bank  = rd_item.req.bank;
        wr.index = rd_item.req.index;
        wr.data  = merged;
    end

    // read response strobe, one cycle per read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= is_read;
        end
    end

    // read data holds until the next read
    always_ff @(posedge clk) begin
        if (is_read) begin
            rd_data <= rd_item.old_word;
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_bank_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_bank_array (
    input  logic                       clk,
    input  logic                       rst_n,
    input  mem_pipe_pkg::decoded_req_t dec,
    input  mem_pipe_pkg::bank_wr_t     wr,
    output mem_pipe_pkg::read_stage_t  rd_item
);

    // read word out of every bank at dec.index
    mem_types_pkg::mem_word_t bank_rd [`MEM_BANKS];
    // selected bank word before forwarding
    mem_types_pkg::mem_word_t stored_word;
    // same-word write at this edge
    logic                     fwd_hit;
    mem_pipe_pkg::read_stage_t rd_d;
    // stage 2 payload, no reset
    mem_pipe_pkg::read_stage_t rd_q;
    logic                     valid_q;

    genvar b;
    generate
        for (b = 0; b < `MEM_BANKS; b++) begin : g_bank
            // storage for one bank, contents not reset
            mem_types_pkg::mem_word_t bank_q [`MEM_BANK_WORDS];
            logic                     bank_we;

            // write enable only for the addressed bank
            assign bank_we = wr.wr_en && (wr.bank == mem_types_pkg::bank_sel_t'(b));

            always_ff @(posedge clk) begin
                if (bank_we) begin
                    bank_q[wr.index] <= wr.data;
                end
            end

            // every bank looks at the same index
            assign bank_rd[b] = bank_q[dec.index];
        end
    endgenerate

    // bank mux on addr[11:7]
    assign stored_word = bank_rd[dec.bank];

    // stage 3 writes this exact word at the same edge
    assign fwd_hit = wr.wr_en && (wr.bank == dec.bank) && (wr.index == dec.index);

    always_comb begin
        rd_d.req = dec;
        // take the merged word so back-to-back requests see it
        rd_d.old_word = fwd_hit ? wr.data : stored_word;
    end

    // stage 2 valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dec.valid;
        end
    end

    // synchronous read result plus the carried request
    always_ff @(posedge clk) begin
        if (dec.valid) begin
            rd_q <= rd_d;
        end
    end

    always_comb begin
        rd_item           = rd_q;
        rd_item.req.valid = valid_q;
    end

endmodule

`default_nettype wire

/* rtl/mem_req_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_req_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       en,
    input  mem_pipe_pkg::mem_req_t     req,
    output logic                       ready,
    output mem_pipe_pkg::decoded_req_t dec
);

    // next stage 1 contents
    mem_pipe_pkg::decoded_req_t dec_d;
    // stage 1 payload, no reset
    mem_pipe_pkg::decoded_req_t dec_q;
    logic                       valid_q;
    // byte offset inside the word
    logic [1:0]                 lane;
    // size used for lane decode
    mem_types_pkg::wr_size_t    size;

    assign lane = req.addr[1:0];

    // reads go down the full word path
    assign size = req.rd_wr ? req.wr_size : `MEM_SIZE_WORD;

    always_comb begin
        // accepted only when both strobe and ready are up
        dec_d.valid = en & ready;
        dec_d.rd_wr = req.rd_wr;
        // address split
        dec_d.bank  = req.addr[11:7];
        dec_d.index = req.addr[6:2];
        case (size)
            `MEM_SIZE_BYTE: begin
                // one lane, picked by addr[1:0]
                dec_d.byte_en = mem_types_pkg::byte_en_t'(4'b0001 << lane);
                dec_d.wr_data = {24'h0, req.wr_data[7:0]} << {lane, 3'b000};
            end
            `MEM_SIZE_HALF: begin
                // upper or lower half by addr[1]
                if (lane[1]) begin
                    dec_d.byte_en = 4'b1100;
                    dec_d.wr_data = {req.wr_data[15:0], 16'h0};
                end else begin
                    dec_d.byte_en = 4'b0011;
                    dec_d.wr_data = {16'h0, req.wr_data[15:0]};
                end
            end
            default: begin
                // word and code 3, all lanes
                dec_d.byte_en = 4'b1111;
                dec_d.wr_data = req.wr_data;
            end
        endcase
    end

    // control flops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            // up from the first edge out of reset
            ready   <= 1'b1;
            valid_q <= dec_d.valid;
        end
    end

    // payload only loads on an accepted request
    always_ff @(posedge clk) begin
        if (dec_d.valid) begin
            dec_q <= dec_d;
        end
    end

    always_comb begin
        dec       = dec_q;
        dec.valid = valid_q;
    end

endmodule

`default_nettype wire

/* rtl/mem_pipe_pkg.sv */
`default_nettype none

package mem_pipe_pkg;

    // request exactly as it sits on the port
    typedef struct packed {
        // 1 for write, 0 for read
        logic                     rd_wr;
        mem_types_pkg::wr_size_t  wr_size;
        mem_types_pkg::mem_addr_t addr;
        // unshifted, byte or half sits in the low bits
        mem_types_pkg::mem_word_t wr_data;
    } mem_req_t;

    // stage 1 register contents
    typedef struct packed {
        logic                     valid;
        logic                     rd_wr;
        mem_types_pkg::bank_sel_t bank;
        mem_types_pkg::word_idx_t index;
        // lanes touched by a write
        mem_types_pkg::byte_en_t  byte_en;
        // write data already moved into its lanes
        mem_types_pkg::mem_word_t wr_data;
    } decoded_req_t;

    // stage 2 register contents
    typedef struct packed {
        decoded_req_t             req;
        // word read from the bank
        // carries the forwarded value on a same-word hit
        mem_types_pkg::mem_word_t old_word;
    } read_stage_t;

    // bank write port, driven from stage 3
    typedef struct packed {
        logic                     wr_en;
        mem_types_pkg::bank_sel_t bank;
        mem_types_pkg::word_idx_t index;
        // merged word to store
        mem_types_pkg::mem_word_t data;
    } bank_wr_t;

endpackage

`default_nettype wire

/* rtl/mem_types_pkg.sv */
`default_nettype none

`include "mem_consts.svh"

package mem_types_pkg;

    // one 32-bit data word
    typedef logic [31:0] mem_word_t;

    // byte address from the processor
    // only bits 11:0 reach the array
    typedef logic [31:0] mem_addr_t;

    // bank number, taken from addr[11:7]
    typedef logic [$clog2(`MEM_BANKS)-1:0] bank_sel_t;

    // word within a bank, from addr[6:2]
    typedef logic [$clog2(`MEM_BANK_WORDS)-1:0] word_idx_t;

    // one enable per byte lane
    // bit 0 is data[7:0]
    typedef logic [3:0] byte_en_t;

    // write size code
    typedef logic [1:0] wr_size_t;

endpackage

`default_nettype wire

/* rtl/mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// memory geometry

// bank count, bank picked by addr[11:7]
`define MEM_BANKS 32

// words in each bank, word picked by addr[6:2]
`define MEM_BANK_WORDS 32

// wr_size encodings as driven on the port

// single byte at any lane
`define MEM_SIZE_BYTE 2'd0
// halfword in lanes 0-1 or 2-3, addr[0] ignored
`define MEM_SIZE_HALF 2'd1
// full word, addr[1:0] ignored
// code 3 takes the same path
`define MEM_SIZE_WORD 2'd2

`endif
